// File: ts_reg_pkg.sv
package ts_reg_pkg;

    localparam int REG_ADDR_W = 8;
    localparam int REG_DATA_W = 32;

    // Timestamp format
    localparam int TS_W      = 64;
    localparam int FRAC_BITS = 28;
    localparam int ACC_W     = TS_W + FRAC_BITS;  // Integer plus fraction

    // 8 whole units per clock
    localparam logic [REG_DATA_W-1:0] INIT_TIMESTAMP_INCR = 32'h8000_0000;

    localparam logic [REG_DATA_W-1:0] TS_INCR_RST   = INIT_TIMESTAMP_INCR;
    localparam logic [REG_DATA_W-1:0] TS_WR_RST     = '0;
    localparam logic                  SNAP_RDY_RST  = 1'b0;

    typedef enum logic [REG_ADDR_W-1:0] {
        TS_INCR   = 8'h00,  // RW
        TS_WR_LO  = 8'h04,  // WO
        TS_WR_HI  = 8'h08,  // WO, triggers load
        TS_RD_REQ = 8'h0C,  // WO, triggers snapshot
        TS_STATUS = 8'h10,  // Bit 0 snapshot ready
        TS_RD_LO  = 8'h14,
        TS_RD_HI  = 8'h18,
        FR_RD_LO  = 8'h1C,
        FR_RD_HI  = 8'h20
    } ts_reg_addr_e;

endpackage

// File: ts_pkt_pkg.sv
package ts_pkt_pkg;

    localparam int BEAT_CNT_W = 16;

    // One descriptor per packet
    typedef struct packed {
        logic [ts_reg_pkg::TS_W-1:0] sop_ts;  // Timestamp at sop beat
        logic [BEAT_CNT_W-1:0]       beats;   // Valid beats incl. sop and eop
    } ts_desc_t;

    typedef enum logic {
        IDLE,
        IN_PKT
    } stamper_state_e;

endpackage

// File: ts_ctrl_if.sv
`timescale 1ns/100ps

interface ts_ctrl_if;

    logic [ts_reg_pkg::REG_DATA_W-1:0] incr;
    logic                              wr_req;      // One-cycle pulse
    logic [ts_reg_pkg::TS_W-1:0]       wr_value;
    logic                              rd_req;      // One-cycle pulse
    logic                              rd_ack;      // One cycle after rd_req
    logic [ts_reg_pkg::TS_W-1:0]       rd_value;
    logic [ts_reg_pkg::TS_W-1:0]       freerun_rd;

    modport regs (
        output incr,
        output wr_req,
        output wr_value,
        output rd_req,
        input  rd_ack,
        input  rd_value,
        input  freerun_rd
    );

    modport counter (
        input  incr,
        input  wr_req,
        input  wr_value,
        input  rd_req,
        output rd_ack,
        output rd_value,
        output freerun_rd
    );

endinterface

// File: ts_counter.sv
`timescale 1ns/100ps

module ts_counter (
    input  logic                        clk,
    input  logic                        srst,
    ts_ctrl_if.counter                  ctrl,
    output logic [ts_reg_pkg::TS_W-1:0] timestamp
);

    logic [ts_reg_pkg::REG_DATA_W:0]  ts_lsbs;   // Low word sum with carry
    logic [ts_reg_pkg::REG_DATA_W:0]  fr_lsbs;
    logic [ts_reg_pkg::ACC_W-1:0]     ts_acc;
    logic [ts_reg_pkg::ACC_W-1:0]     fr_acc;
    logic [ts_reg_pkg::ACC_W-1:0]     load_acc;
    logic [ts_reg_pkg::TS_W-1:0]      ts_p;
    logic [ts_reg_pkg::TS_W-1:0]      ts_latch;
    logic [ts_reg_pkg::TS_W-1:0]      fr_latch;

    assign load_acc = {ctrl.wr_value, {ts_reg_pkg::FRAC_BITS{1'b0}}};

    // Carry out of the low word lands in the upper bits a cycle later
    always_ff @(posedge clk) begin
        if (srst) begin
            ts_lsbs <= '0;
            ts_acc  <= '0;
            fr_lsbs <= '0;
            fr_acc  <= '0;
        end else if (ctrl.wr_req) begin
            ts_lsbs <= {1'b0, load_acc[ts_reg_pkg::REG_DATA_W-1:0]};
            ts_acc  <= load_acc;
            fr_lsbs <= {1'b0, load_acc[ts_reg_pkg::REG_DATA_W-1:0]};
            fr_acc  <= load_acc;
        end else begin
            ts_lsbs <= {1'b0, ts_lsbs[ts_reg_pkg::REG_DATA_W-1:0]} + {1'b0, ctrl.incr};
            ts_acc[ts_reg_pkg::REG_DATA_W-1:0] <= ts_lsbs[ts_reg_pkg::REG_DATA_W-1:0];
            ts_acc[ts_reg_pkg::ACC_W-1:ts_reg_pkg::REG_DATA_W] <=
                ts_acc[ts_reg_pkg::ACC_W-1:ts_reg_pkg::REG_DATA_W]
                + {{(ts_reg_pkg::ACC_W-ts_reg_pkg::REG_DATA_W-1){1'b0}},
                   ts_lsbs[ts_reg_pkg::REG_DATA_W]};

            // Nominal rate, ignores the programmed increment
            fr_lsbs <= {1'b0, fr_lsbs[ts_reg_pkg::REG_DATA_W-1:0]}
                       + {1'b0, ts_reg_pkg::INIT_TIMESTAMP_INCR};
            fr_acc[ts_reg_pkg::REG_DATA_W-1:0] <= fr_lsbs[ts_reg_pkg::REG_DATA_W-1:0];
            fr_acc[ts_reg_pkg::ACC_W-1:ts_reg_pkg::REG_DATA_W] <=
                fr_acc[ts_reg_pkg::ACC_W-1:ts_reg_pkg::REG_DATA_W]
                + {{(ts_reg_pkg::ACC_W-ts_reg_pkg::REG_DATA_W-1){1'b0}},
                   fr_lsbs[ts_reg_pkg::REG_DATA_W]};
        end
    end

    // Two-stage output pipeline on the integer part
    always_ff @(posedge clk) begin
        ts_p      <= ts_acc[ts_reg_pkg::ACC_W-1:ts_reg_pkg::FRAC_BITS];
        timestamp <= ts_p;
    end

    always_ff @(posedge clk) begin
        if (ctrl.rd_req) begin
            ts_latch <= timestamp;
            fr_latch <= fr_acc[ts_reg_pkg::ACC_W-1:ts_reg_pkg::FRAC_BITS];
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            ctrl.rd_ack <= 1'b0;
        end else begin
            ctrl.rd_ack <= ctrl.rd_req;  // Snapshot valid from here
        end
    end

    assign ctrl.rd_value   = ts_latch;
    assign ctrl.freerun_rd = fr_latch;

endmodule

// File: ts_regs.sv
`timescale 1ns/100ps

module ts_regs (
    input  logic                              clk,
    input  logic                              srst,
    input  logic                              reg_wr_en,
    input  logic                              reg_rd_en,
    input  logic [ts_reg_pkg::REG_ADDR_W-1:0] reg_addr,
    input  logic [ts_reg_pkg::REG_DATA_W-1:0] reg_wdata,
    output logic [ts_reg_pkg::REG_DATA_W-1:0] reg_rdata,
    output logic                              reg_rvalid,
    ts_ctrl_if.regs                           ctrl
);

    ts_reg_pkg::ts_reg_addr_e           addr;
    logic [ts_reg_pkg::REG_DATA_W-1:0]  incr_q;
    logic [ts_reg_pkg::REG_DATA_W-1:0]  wr_lo;
    logic [ts_reg_pkg::REG_DATA_W-1:0]  wr_hi;
    logic                               snap_rdy;
    logic                               wr_incr;
    logic                               wr_lo_sel;
    logic                               wr_hi_sel;
    logic                               wr_rd_req;
    logic [ts_reg_pkg::REG_DATA_W-1:0]  rd_mux;

    assign addr = ts_reg_pkg::ts_reg_addr_e'(reg_addr);

    // Write decode, unknown addresses fall through
    assign wr_incr   = reg_wr_en && (addr == ts_reg_pkg::TS_INCR);
    assign wr_lo_sel = reg_wr_en && (addr == ts_reg_pkg::TS_WR_LO);
    assign wr_hi_sel = reg_wr_en && (addr == ts_reg_pkg::TS_WR_HI);
    assign wr_rd_req = reg_wr_en && (addr == ts_reg_pkg::TS_RD_REQ);

    always_ff @(posedge clk) begin
        if (srst) begin
            incr_q <= ts_reg_pkg::TS_INCR_RST;
            wr_lo  <= ts_reg_pkg::TS_WR_RST;
            wr_hi  <= ts_reg_pkg::TS_WR_RST;
        end else begin
            if (wr_incr) begin
                incr_q <= reg_wdata;
            end
            if (wr_lo_sel) begin
                wr_lo <= reg_wdata;
            end
            if (wr_hi_sel) begin
                wr_hi <= reg_wdata;
            end
        end
    end

    // Strobe pulses toward the counter
    always_ff @(posedge clk) begin
        if (srst) begin
            ctrl.wr_req <= 1'b0;
            ctrl.rd_req <= 1'b0;
        end else begin
            ctrl.wr_req <= wr_hi_sel;  // HI write commits the load
            ctrl.rd_req <= wr_rd_req;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            snap_rdy <= ts_reg_pkg::SNAP_RDY_RST;
        end else if (wr_rd_req) begin
            snap_rdy <= 1'b0;  // New request wins over a late ack
        end else if (ctrl.rd_ack) begin
            snap_rdy <= 1'b1;
        end
    end

    always_comb begin
        case (addr)
            ts_reg_pkg::TS_INCR:   rd_mux = incr_q;
            ts_reg_pkg::TS_STATUS: rd_mux = {{(ts_reg_pkg::REG_DATA_W-1){1'b0}}, snap_rdy};
            ts_reg_pkg::TS_RD_LO:  rd_mux = ctrl.rd_value[ts_reg_pkg::REG_DATA_W-1:0];
            ts_reg_pkg::TS_RD_HI:  rd_mux = ctrl.rd_value[ts_reg_pkg::TS_W-1:ts_reg_pkg::REG_DATA_W];
            ts_reg_pkg::FR_RD_LO:  rd_mux = ctrl.freerun_rd[ts_reg_pkg::REG_DATA_W-1:0];
            ts_reg_pkg::FR_RD_HI:
                rd_mux = ctrl.freerun_rd[ts_reg_pkg::TS_W-1:ts_reg_pkg::REG_DATA_W];
            default:               rd_mux = '0;  // Write-only and unmapped
        endcase
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd_en) begin
            reg_rdata <= rd_mux;
        end
    end

    assign ctrl.incr     = incr_q;
    assign ctrl.wr_value = {wr_hi, wr_lo};

endmodule

// File: ts_desc_stamper.sv
`timescale 1ns/100ps

module ts_desc_stamper (
    input  logic                        clk,
    input  logic                        srst,
    input  logic [ts_reg_pkg::TS_W-1:0] timestamp,
    input  logic                        pkt_valid,
    input  logic                        pkt_sop,
    input  logic                        pkt_eop,
    output logic                        desc_valid,
    output ts_pkt_pkg::ts_desc_t        desc
);

    ts_pkt_pkg::stamper_state_e         state;
    logic [ts_reg_pkg::TS_W-1:0]        sop_ts;
    logic [ts_reg_pkg::TS_W-1:0]        sop_ts_nxt;
    logic [ts_pkt_pkg::BEAT_CNT_W-1:0]  beat_cnt;
    logic [ts_pkt_pkg::BEAT_CNT_W-1:0]  beat_cnt_nxt;
    logic                               pkt_beat;
    logic                               pkt_end;

    // Beats outside a packet are dropped, sop restarts capture
    assign pkt_beat = pkt_valid && (pkt_sop || (state == ts_pkt_pkg::IN_PKT));
    assign pkt_end  = pkt_beat && pkt_eop;

    assign sop_ts_nxt   = pkt_sop ? timestamp : sop_ts;
    assign beat_cnt_nxt = pkt_sop ? {{(ts_pkt_pkg::BEAT_CNT_W-1){1'b0}}, 1'b1}
                                  : beat_cnt + 1'b1;

    always_ff @(posedge clk) begin
        if (srst) begin
            state <= ts_pkt_pkg::IDLE;
        end else if (pkt_beat) begin
            state <= pkt_eop ? ts_pkt_pkg::IDLE : ts_pkt_pkg::IN_PKT;
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_beat) begin
            sop_ts   <= sop_ts_nxt;
            beat_cnt <= beat_cnt_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            desc_valid <= 1'b0;
        end else begin
            desc_valid <= pkt_end;  // Cycle after eop
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_end) begin
            desc.sop_ts <= sop_ts_nxt;
            desc.beats  <= beat_cnt_nxt;
        end
    end

endmodule

// File: ts_top.sv
`timescale 1ns/100ps

module ts_top (
    input  logic                                clk,
    input  logic                                srst,

    input  logic                                reg_wr_en,
    input  logic                                reg_rd_en,
    input  logic [ts_reg_pkg::REG_ADDR_W-1:0]   reg_addr,
    input  logic [ts_reg_pkg::REG_DATA_W-1:0]   reg_wdata,
    output logic [ts_reg_pkg::REG_DATA_W-1:0]   reg_rdata,
    output logic                                reg_rvalid,

    input  logic                                pkt_valid,
    input  logic                                pkt_sop,
    input  logic                                pkt_eop,

    output logic                                desc_valid,
    output logic [ts_reg_pkg::TS_W-1:0]         desc_ts,
    output logic [ts_pkt_pkg::BEAT_CNT_W-1:0]   desc_beats
);

    logic [ts_reg_pkg::TS_W-1:0]  timestamp;
    ts_pkt_pkg::ts_desc_t         desc;

    ts_ctrl_if ctrl ();

    ts_regs u_regs (
        .clk        (clk),
        .srst       (srst),
        .reg_wr_en  (reg_wr_en),
        .reg_rd_en  (reg_rd_en),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .ctrl       (ctrl.regs)
    );

    ts_counter u_counter (
        .clk        (clk),
        .srst       (srst),
        .ctrl       (ctrl.counter),
        .timestamp  (timestamp)
    );

    ts_desc_stamper u_stamper (
        .clk        (clk),
        .srst       (srst),
        .timestamp  (timestamp),
        .pkt_valid  (pkt_valid),
        .pkt_sop    (pkt_sop),
        .pkt_eop    (pkt_eop),
        .desc_valid (desc_valid),
        .desc       (desc)
    );

    assign desc_ts    = desc.sop_ts;
    assign desc_beats = desc.beats;

endmodule

// File: tb_ts_top.sv
`timescale 1ns/100ps

module tb_ts_top;

    localparam int     CLK_PERIOD  = 20;
    localparam int     NUM_PKTS    = 10;
    localparam int     TEST_CYCLES = 40 + 80 + 40 + 200 + 120 + 400;  // Per-test budgets
    localparam longint WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;
    // Whole units added per clock at the nominal increment
    localparam longint STEP = ts_reg_pkg::INIT_TIMESTAMP_INCR >> ts_reg_pkg::FRAC_BITS;

    logic                                clk;
    logic                                srst;
    logic                                reg_wr_en;
    logic                                reg_rd_en;
    logic [ts_reg_pkg::REG_ADDR_W-1:0]   reg_addr;
    logic [ts_reg_pkg::REG_DATA_W-1:0]   reg_wdata;
    logic [ts_reg_pkg::REG_DATA_W-1:0]   reg_rdata;
    logic                                reg_rvalid;
    logic                                pkt_valid;
    logic                                pkt_sop;
    logic                                pkt_eop;
    logic                                desc_valid;
    logic [ts_reg_pkg::TS_W-1:0]         desc_ts;
    logic [ts_pkt_pkg::BEAT_CNT_W-1:0]   desc_beats;

    int    errors;
    int    test_start_errors;
    int    tests_run;
    int    tests_passed;
    string test_name;

    ts_top uut (
        .clk        (clk),
        .srst       (srst),
        .reg_wr_en  (reg_wr_en),
        .reg_rd_en  (reg_rd_en),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .pkt_valid  (pkt_valid),
        .pkt_sop    (pkt_sop),
        .pkt_eop    (pkt_eop),
        .desc_valid (desc_valid),
        .desc_ts    (desc_ts),
        .desc_beats (desc_beats)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

    rvalid_after_rd: assert property (@(posedge clk) disable iff (srst)
        reg_rd_en |=> reg_rvalid)
        else begin
            errors++;
            $display("%0t: reg_rvalid did not follow reg_rd_en by one cycle", $time);
        end

    rvalid_only_after_rd: assert property (@(posedge clk) disable iff (srst)
        reg_rvalid |-> $past(reg_rd_en))
        else begin
            errors++;
            $display("%0t: reg_rvalid pulsed without a read one cycle earlier", $time);
        end

    desc_after_eop: assert property (@(posedge clk) disable iff (srst)
        (pkt_valid && pkt_eop) |=> desc_valid)
        else begin
            errors++;
            $display("%0t: desc_valid did not follow the eop beat by one cycle", $time);
        end

    desc_only_after_eop: assert property (@(posedge clk) disable iff (srst)
        desc_valid |-> $past(pkt_valid && pkt_eop))
        else begin
            errors++;
            $display("%0t: desc_valid pulsed without an eop beat one cycle earlier", $time);
        end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input string what, input bit cond);
        assert (cond) else begin
            errors++;
            $display("%0t: %s", $time, what);
        end
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_start_errors = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("test %0d %s: ok", tests_run, test_name);
        end else begin
            $display("test %0d %s: failed", tests_run, test_name);
        end
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        reg_wr_en = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr_en = 1'b0;
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
        int waited;
        @(negedge clk);
        reg_rd_en = 1'b1;
        reg_addr  = addr;
        @(negedge clk);
        reg_rd_en = 1'b0;
        waited    = 0;
        while (!reg_rvalid && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        check_true("register read got no reg_rvalid", reg_rvalid);
        data = reg_rdata;
    endtask

    function automatic logic [63:0] random_value();
        logic [63:0] v;
        v       = {$urandom, $urandom};
        v[63]   = 1'b0;  // Headroom so later snapshots cannot wrap
        return v;
    endfunction

    task automatic load_value(input logic [63:0] w);
        reg_write(ts_reg_pkg::TS_WR_LO, w[31:0]);
        reg_write(ts_reg_pkg::TS_WR_HI, w[63:32]);
        repeat (4) @(negedge clk);  // Load reaches the timestamp output in 3
    endtask

    task automatic wait_snapshot_ready();
        logic [31:0] status;
        int          polls;
        status = '0;
        polls  = 0;
        while (!status[0] && polls < 8) begin
            reg_read(ts_reg_pkg::TS_STATUS, status);
            polls++;
        end
        check_true("snapshot ready bit never set", status[0]);
    endtask

    task automatic take_snapshot(output logic [63:0] ts, output logic [63:0] fr);
        logic [31:0] lo;
        logic [31:0] hi;
        reg_write(ts_reg_pkg::TS_RD_REQ, 32'h0);
        wait_snapshot_ready();
        reg_read(ts_reg_pkg::TS_RD_LO, lo);
        reg_read(ts_reg_pkg::TS_RD_HI, hi);
        ts = {hi, lo};
        reg_read(ts_reg_pkg::FR_RD_LO, lo);
        reg_read(ts_reg_pkg::FR_RD_HI, hi);
        fr = {hi, lo};
    endtask

    task automatic send_packet(input int len);
        for (int i = 0; i < len; i++) begin
            if (i > 0 && ($urandom % 4) == 0) begin
                @(negedge clk);
                pkt_valid = 1'b0;  // Idle cycle inside the packet
                pkt_sop   = 1'b0;
                pkt_eop   = 1'b0;
            end
            @(negedge clk);
            pkt_valid = 1'b1;
            pkt_sop   = (i == 0);
            pkt_eop   = (i == len - 1);
        end
        @(negedge clk);
        pkt_valid = 1'b0;
        pkt_sop   = 1'b0;
        pkt_eop   = 1'b0;
    endtask

    task automatic check_descriptor(input logic [63:0] exp_ts, input int exp_beats);
        int waited;
        waited = 0;
        while (!desc_valid && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        check_true("no descriptor after the eop beat", desc_valid);
        check_value("desc_ts", desc_ts, exp_ts);
        check_value("desc_beats", 64'(desc_beats), 64'(exp_beats));
    endtask

    initial begin
        logic [31:0] rd;
        logic [63:0] w;
        logic [63:0] ts1;
        logic [63:0] fr1;
        logic [63:0] ts2;
        logic [63:0] fr2;
        int          len;

        void'($urandom(56));
        errors       = 0;
        tests_run    = 0;
        tests_passed = 0;
        srst         = 1'b1;
        reg_wr_en    = 1'b0;
        reg_rd_en    = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        pkt_valid    = 1'b0;
        pkt_sop      = 1'b0;
        pkt_eop      = 1'b0;
        repeat (4) @(negedge clk);
        srst = 1'b0;

        start_test("reset_values");
        reg_read(ts_reg_pkg::TS_INCR, rd);
        check_value("TS_INCR", 64'(rd), 64'(ts_reg_pkg::INIT_TIMESTAMP_INCR));
        reg_read(ts_reg_pkg::TS_STATUS, rd);
        check_value("TS_STATUS", 64'(rd), 64'h0);
        reg_read(8'hFC, rd);
        check_value("unmapped", 64'(rd), 64'h0);
        end_test();

        start_test("load_frozen_read");
        reg_write(ts_reg_pkg::TS_INCR, 32'h0);
        w = random_value();
        load_value(w);
        take_snapshot(ts1, fr1);
        check_value("TS_RD_LO", 64'(ts1[31:0]), 64'(w[31:0]));
        check_value("TS_RD_HI", 64'(ts1[63:32]), 64'(w[63:32]));
        end_test();

        start_test("snapshot_handshake");
        reg_write(ts_reg_pkg::TS_RD_REQ, 32'h0);
        reg_read(ts_reg_pkg::TS_STATUS, rd);
        check_value("TS_STATUS", 64'(rd[0]), 64'h0);
        wait_snapshot_ready();
        end_test();

        start_test("nominal_increment");
        reg_write(ts_reg_pkg::TS_INCR, ts_reg_pkg::INIT_TIMESTAMP_INCR);
        w = random_value();
        load_value(w);
        take_snapshot(ts1, fr1);
        check_true("free-running behind timestamp", fr1 >= ts1);
        check_true("free-running leads by more than two steps", fr1 - ts1 <= 2 * STEP);
        repeat (50) @(negedge clk);
        take_snapshot(ts2, fr2);
        check_true("timestamp did not advance", ts2 > ts1);
        check_true("timestamp advance not a whole step", (ts2 - ts1) % STEP == 0);
        check_true("free-running advance not a whole step", (fr2 - fr1) % STEP == 0);
        end_test();

        start_test("frozen_vs_freerun");
        reg_write(ts_reg_pkg::TS_INCR, 32'h0);
        w = random_value();
        load_value(w);
        take_snapshot(ts1, fr1);
        repeat (20) @(negedge clk);
        take_snapshot(ts2, fr2);
        check_value("TS_RD", ts2, ts1);
        check_true("free-running counter did not grow", fr2 > fr1);
        end_test();

        start_test("descriptors");
        w = random_value();
        load_value(w);
        for (int p = 0; p < NUM_PKTS; p++) begin
            len = (p == 0) ? 1 : 1 + int'($urandom % 8);  // First one is single-beat
            send_packet(len);
            check_descriptor(w, len);
        end
        end_test();

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
ts_reg_pkg.sv
ts_pkt_pkg.sv
ts_ctrl_if.sv
ts_counter.sv
ts_regs.sv
ts_desc_stamper.sv
ts_top.sv
tb_ts_top.sv

// File: Makefile
TOP = tb_ts_top

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f filelist.f -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
